// File: design/lsu_multipop_fifo.sv
`timescale 1ns/1ps
`include "lsu_remap_macros.svh"

module lsu_multipop_fifo #(
  parameter int WIDTH = 8
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               push_valid,
  output logic                               push_ready,
  input  logic [WIDTH-1:0]                   push_data,
  output logic [`NUM_LSU-1:0][WIDTH-1:0]     head,
  output logic                               empty,
  output logic [`NUM_LSU-1:0]                almost_empty,
  input  logic [`NUM_LSU-1:0]                pop
);

  localparam int DEPTH = `MAP_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  // one extra bit so pointer sums can be wrapped
  localparam int IDX_W = PTR_W + 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int POP_W = $clog2(`NUM_LSU + 1);

  logic [WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic             push_fire;
  logic [POP_W-1:0] pop_cnt;
  logic [PTR_W-1:0] wr_ptr_next;
  logic [IDX_W-1:0] rd_sum;
  logic [IDX_W-1:0] rd_wrap;

  assign push_ready = (count != CNT_W'(DEPTH));
  assign push_fire  = push_valid & push_ready;
  assign empty      = (count == '0);

  // length of the leading-ones run in pop
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < `NUM_LSU; i++) begin
      if (pop[i] && (pop_cnt == POP_W'(i))) begin
        pop_cnt = pop_cnt + 1'b1;
      end
    end
  end

  assign wr_ptr_next = (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

  assign rd_sum  = {1'b0, rd_ptr} + IDX_W'(pop_cnt);
  assign rd_wrap = (rd_sum >= IDX_W'(DEPTH)) ? rd_sum - IDX_W'(DEPTH) : rd_sum;

  // lane i reads the i-th entry after the read pointer
  for (genvar i = 0; i < `NUM_LSU; i++) begin : g_lane
    logic [IDX_W-1:0] raw_idx;
    logic [IDX_W-1:0] wrap_idx;

    assign raw_idx  = {1'b0, rd_ptr} + IDX_W'(i);
    assign wrap_idx = (raw_idx >= IDX_W'(DEPTH)) ? raw_idx - IDX_W'(DEPTH) : raw_idx;
    assign head[i]  = mem[wrap_idx[PTR_W-1:0]];

    // fewer than i+1 entries held
    assign almost_empty[i] = (count <= CNT_W'(i));
  end

  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr_next;
      end
      rd_ptr <= rd_wrap[PTR_W-1:0];
      count  <= count + CNT_W'(push_fire) - CNT_W'(pop_cnt);
    end
  end

endmodule

// File: design/lsu_remap.sv
`timescale 1ns/1ps
`include "lsu_remap_macros.svh"

module lsu_remap
  import lsu_remap_pkg::*;
(
  input  lsu_map_info_t [`NUM_LSU-1:0]                       mapinfo,
  input  uop_lsu_t      [`NUM_LSU-1:0]                       lsu_res,
  input  logic                                               mapinfo_empty,
  input  logic          [`NUM_LSU-1:0]                       mapinfo_almost_empty,
  input  logic                                               lsu_res_empty,
  input  logic          [`NUM_LSU-1:0]                       lsu_res_almost_empty,
  output logic          [`NUM_LSU-1:0]                       pop_mapinfo,
  output logic          [`NUM_LSU-1:0]                       pop_lsu_res,

  output logic          [`NUM_LSU-1:0]                       result_valid,
  output logic          [`NUM_LSU-1:0][`ROB_DEPTH_WIDTH-1:0] result_rob_entry,
  output logic          [`NUM_LSU-1:0]                       result_w_valid,
  output logic          [`NUM_LSU-1:0][`VLEN-1:0]            result_w_data,
  input  logic          [`NUM_LSU-1:0]                       result_ready,

  output logic                                               trap_valid,
  output logic          [`ROB_DEPTH_WIDTH-1:0]               trap_rob_entry,
  input  logic                                               trap_ready
);

  logic [`NUM_LSU-1:0] pairable;
  logic [`NUM_LSU-1:0] lane_trap;
  // pops that do not involve the trap port
  logic [`NUM_LSU-1:0] clear_pop;
  logic [`NUM_LSU-1:0] want_pop;

  // lane 0 only needs both queues non-empty
  assign pairable[0] = !mapinfo_empty & !lsu_res_empty;

  for (genvar i = 1; i < `NUM_LSU; i++) begin : g_pair
    assign pairable[i] = !mapinfo_almost_empty[i] & !lsu_res_almost_empty[i];
  end

  for (genvar i = 0; i < `NUM_LSU; i++) begin : g_lane
    logic load_done;
    logic store_done;

    assign load_done  = (mapinfo[i].lsu_class == is_load) & lsu_res[i].vregfile_write_valid;
    assign store_done = (mapinfo[i].lsu_class == is_store) & lsu_res[i].vstore_last;

    assign lane_trap[i] = pairable[i] & mapinfo[i].valid & lsu_res[i].trap_valid;

    assign result_valid[i] = pairable[i] & mapinfo[i].valid & !lsu_res[i].trap_valid &
                             (load_done | store_done);

    assign result_rob_entry[i] = mapinfo[i].rob_entry;
    assign result_w_data[i]    = lsu_res[i].vregfile_write_data;
    // only a load hitting its mapped register writes back
    assign result_w_valid[i]   = load_done &
                                 (lsu_res[i].vregfile_write_addr == mapinfo[i].vregfile_write_addr);

    assign clear_pop[i] = (result_valid[i] & result_ready[i]) |
                          (pairable[i] & !mapinfo[i].valid);
    assign want_pop[i]  = clear_pop[i] | (lane_trap[i] & trap_ready);
  end

  // in-order retirement, a lane pops only behind popping lanes
  assign pop_mapinfo[0] = want_pop[0];

  for (genvar i = 1; i < `NUM_LSU; i++) begin : g_chain
    assign pop_mapinfo[i] = want_pop[i] & pop_mapinfo[i-1];
  end

  assign pop_lsu_res = pop_mapinfo;

  // lowest trapping lane whose lower lanes all retire
  always_comb begin
    logic lower_ok;

    lower_ok       = 1'b1;
    trap_valid     = 1'b0;
    trap_rob_entry = '0;
    for (int j = 0; j < `NUM_LSU; j++) begin
      if (lower_ok && lane_trap[j] && !trap_valid) begin
        trap_valid     = 1'b1;
        trap_rob_entry = mapinfo[j].rob_entry;
      end
      lower_ok = lower_ok & clear_pop[j];
    end
  end

endmodule

// File: design/lsu_remap_macros.svh
`ifndef LSU_REMAP_MACROS_SVH
`define LSU_REMAP_MACROS_SVH

// lanes handed to the ROB per cycle
`define NUM_LSU 2

// entries in each of the two queues
`define MAP_FIFO_DEPTH 8

// width of a ROB index
`define ROB_DEPTH_WIDTH 4

// write data width, one vector register slice
`define VLEN 32

// vector register file index
`define VREG_ADDR_WIDTH 5

`endif

// File: design/lsu_remap_pkg.sv
`include "lsu_remap_macros.svh"

package lsu_remap_pkg;

  // kind of memory micro-op a record belongs to
  typedef enum logic {
    is_load  = 1'b0,
    is_store = 1'b1
  } lsu_class_e;

  // pushed by dispatch, one per memory micro-op
  typedef struct packed {
    // clear means no operation, retired silently
    logic                          valid;
    logic [`ROB_DEPTH_WIDTH-1:0]   rob_entry;
    lsu_class_e                    lsu_class;
    // register the load is expected to write
    logic [`VREG_ADDR_WIDTH-1:0]   vregfile_write_addr;
  } lsu_map_info_t;

  // pushed by the LSU in the same order as the records
  typedef struct packed {
    logic                          trap_valid;
    logic                          vregfile_write_valid;
    logic [`VREG_ADDR_WIDTH-1:0]   vregfile_write_addr;
    logic [`VLEN-1:0]              vregfile_write_data;
    // last beat of a store
    logic                          vstore_last;
  } uop_lsu_t;

endpackage

// File: design/lsu_writeback_top.sv
`timescale 1ns/1ps
`include "lsu_remap_macros.svh"

module lsu_writeback_top
  import lsu_remap_pkg::*;
(
  input  logic                                       clk,
  input  logic                                       rst,

  // dispatch side
  input  logic                                       map_valid,
  output logic                                       map_ready,
  input  lsu_map_info_t                              map_data,

  // LSU side
  input  logic                                       res_valid,
  output logic                                       res_ready,
  input  uop_lsu_t                                   res_data,

  // ROB completions, one per lane
  output logic [`NUM_LSU-1:0]                        result_valid,
  output logic [`NUM_LSU-1:0][`ROB_DEPTH_WIDTH-1:0]  result_rob_entry,
  output logic [`NUM_LSU-1:0]                        result_w_valid,
  output logic [`NUM_LSU-1:0][`VLEN-1:0]             result_w_data,
  input  logic [`NUM_LSU-1:0]                        result_ready,

  // ROB trap
  output logic                                       trap_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0]                trap_rob_entry,
  input  logic                                       trap_ready
);

  lsu_map_info_t [`NUM_LSU-1:0] map_head;
  uop_lsu_t      [`NUM_LSU-1:0] res_head;
  logic                         map_empty;
  logic                         res_empty;
  logic          [`NUM_LSU-1:0] map_almost_empty;
  logic          [`NUM_LSU-1:0] res_almost_empty;
  logic          [`NUM_LSU-1:0] pop_map;
  logic          [`NUM_LSU-1:0] pop_res;

  lsu_multipop_fifo #(
    .WIDTH($bits(lsu_map_info_t))
  ) map_fifo0 (
    .clk          (clk),
    .rst          (rst),
    .push_valid   (map_valid),
    .push_ready   (map_ready),
    .push_data    (map_data),
    .head         (map_head),
    .empty        (map_empty),
    .almost_empty (map_almost_empty),
    .pop          (pop_map)
  );

  lsu_multipop_fifo #(
    .WIDTH($bits(uop_lsu_t))
  ) res_fifo0 (
    .clk          (clk),
    .rst          (rst),
    .push_valid   (res_valid),
    .push_ready   (res_ready),
    .push_data    (res_data),
    .head         (res_head),
    .empty        (res_empty),
    .almost_empty (res_almost_empty),
    .pop          (pop_res)
  );

  lsu_remap remap0 (
    .mapinfo              (map_head),
    .lsu_res              (res_head),
    .mapinfo_empty        (map_empty),
    .mapinfo_almost_empty (map_almost_empty),
    .lsu_res_empty        (res_empty),
    .lsu_res_almost_empty (res_almost_empty),
    .pop_mapinfo          (pop_map),
    .pop_lsu_res          (pop_res),
    .result_valid         (result_valid),
    .result_rob_entry     (result_rob_entry),
    .result_w_valid       (result_w_valid),
    .result_w_data        (result_w_data),
    .result_ready         (result_ready),
    .trap_valid           (trap_valid),
    .trap_rob_entry       (trap_rob_entry),
    .trap_ready           (trap_ready)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lsu_writeback -f verilog.f -o sim_lsu_writeback \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/sim_lsu_writeback)"
echo "${sim_out}"
echo "${sim_out}" | grep -qx "TEST PASSED" && exit 0 || exit 1

// File: test/lsu_writeback_asserts.sv
`timescale 1ns/1ps
`include "lsu_remap_macros.svh"

module lsu_writeback_asserts (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [`NUM_LSU-1:0]                        pop_mapinfo,
  input  logic [`NUM_LSU-1:0]                        result_valid,
  input  logic [`NUM_LSU-1:0][`ROB_DEPTH_WIDTH-1:0]  result_rob_entry,
  input  logic [`NUM_LSU-1:0][`VLEN-1:0]             result_w_data,
  input  logic                                       trap_valid,
  input  logic                                       trap_ready,
  input  logic [`ROB_DEPTH_WIDTH-1:0]                trap_rob_entry
);

  // an unaccepted trap keeps its entry until trap_ready
  trap_held: assert property (
    @(posedge clk) disable iff (rst)
      trap_valid && !trap_ready |=> trap_valid && $stable(trap_rob_entry)
  ) else $error("trap dropped or changed before trap_ready");

  for (genvar i = 0; i < `NUM_LSU; i++) begin : g_lane
    // nothing retired so every head stays put
    result_held: assert property (
      @(posedge clk) disable iff (rst)
        result_valid[i] && (pop_mapinfo == '0) |=>
          result_valid[i] && $stable(result_rob_entry[i]) && $stable(result_w_data[i])
    ) else $error("lane %0d completion changed while no entry retired", i);
  end

  // first lane left behind moves down to lane 0
  for (genvar i = 1; i < `NUM_LSU; i++) begin : g_shift
    in_order_shift: assert property (
      @(posedge clk) disable iff (rst)
        pop_mapinfo[i-1] && !pop_mapinfo[i] && result_valid[i] |=>
          result_valid[0] && (result_rob_entry[0] == $past(result_rob_entry[i]))
    ) else $error("lane %0d completion did not move to lane 0 after retiring", i);
  end

endmodule

// File: test/lsu_writeback_checker.sv
`timescale 1ns/1ps
`include "lsu_remap_macros.svh"

module lsu_writeback_checker
  import lsu_remap_pkg::*;
(
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       map_valid,
  input  logic                                       map_ready,
  input  lsu_map_info_t                              map_data,
  input  logic                                       res_valid,
  input  logic                                       res_ready,
  input  uop_lsu_t                                   res_data,
  input  logic [`NUM_LSU-1:0]                        result_valid,
  input  logic [`NUM_LSU-1:0][`ROB_DEPTH_WIDTH-1:0]  result_rob_entry,
  input  logic [`NUM_LSU-1:0]                        result_w_valid,
  input  logic [`NUM_LSU-1:0][`VLEN-1:0]             result_w_data,
  input  logic [`NUM_LSU-1:0]                        result_ready,
  input  logic                                       trap_valid,
  input  logic [`ROB_DEPTH_WIDTH-1:0]                trap_rob_entry,
  input  logic                                       trap_ready,
  output int                                         errors,
  output int                                         retired,
  output int                                         completed,
  output int                                         traps_taken
);

  // model of what each queue holds from the head
  lsu_map_info_t map_q[$];
  uop_lsu_t      res_q[$];

  function automatic int check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %0h, got %0h at %0t", name, expected, actual, $time);
      return 1;
    end
    return 0;
  endfunction

  task automatic step_model();
    logic [`NUM_LSU-1:0] is_trap;
    logic [`NUM_LSU-1:0] done;
    logic [`NUM_LSU-1:0] takes;
    logic [`NUM_LSU-1:0] exp_wv;
    logic                exp_trap;
    logic                chain;
    int                  trap_lane;
    int                  n_err;
    int                  n_pop;
    int                  n_done;
    int                  n_trap;
    lsu_map_info_t       m;
    uop_lsu_t            r;

    n_err  = 0;
    n_pop  = 0;
    n_done = 0;
    n_trap = 0;
    n_err += check_value("map_ready", map_q.size() < `MAP_FIFO_DEPTH, map_ready);
    n_err += check_value("res_ready", res_q.size() < `MAP_FIFO_DEPTH, res_ready);

    for (int i = 0; i < `NUM_LSU; i++) begin
      is_trap[i] = 1'b0;
      done[i]    = 1'b0;
      takes[i]   = 1'b0;
      exp_wv[i]  = 1'b0;
      if (map_q.size() > i && res_q.size() > i) begin
        m = map_q[i];
        r = res_q[i];
        if (!m.valid) begin
          // no operation behind this record
          takes[i] = 1'b1;
        end else if (r.trap_valid) begin
          is_trap[i] = 1'b1;
        end else if (m.lsu_class == is_load) begin
          done[i]   = r.vregfile_write_valid;
          exp_wv[i] = r.vregfile_write_addr == m.vregfile_write_addr;
        end else begin
          done[i] = r.vstore_last;
        end
        if (done[i]) begin
          takes[i] = result_ready[i];
          n_err += check_value($sformatf("result_rob_entry[%0d]", i),
                               m.rob_entry, result_rob_entry[i]);
          n_err += check_value($sformatf("result_w_valid[%0d]", i), exp_wv[i], result_w_valid[i]);
          n_err += check_value($sformatf("result_w_data[%0d]", i),
                               r.vregfile_write_data, result_w_data[i]);
        end
      end
      n_err += check_value($sformatf("result_valid[%0d]", i), done[i], result_valid[i]);
    end

    // lowest trapping lane is shown once all lanes below it retire
    trap_lane = -1;
    for (int i = `NUM_LSU - 1; i >= 0; i--) begin
      if (is_trap[i]) begin
        trap_lane = i;
      end
    end
    exp_trap = (trap_lane >= 0);
    for (int j = 0; j < trap_lane; j++) begin
      if (!takes[j]) begin
        exp_trap = 1'b0;
      end
    end
    n_err += check_value("trap_valid", exp_trap, trap_valid);
    if (exp_trap) begin
      n_err += check_value("trap_rob_entry", map_q[trap_lane].rob_entry, trap_rob_entry);
    end

    chain = 1'b1;
    for (int i = 0; i < `NUM_LSU; i++) begin
      chain = chain & (takes[i] | (is_trap[i] & trap_ready));
      if (chain) begin
        n_pop++;
        // completions the DUT handed over on a retiring lane
        if (result_valid[i]) begin
          n_done++;
        end
        if (is_trap[i] && exp_trap && i == trap_lane) begin
          n_trap++;
        end
      end
    end

    repeat (n_pop) begin
      void'(map_q.pop_front());
      void'(res_q.pop_front());
    end
    if (map_valid && map_ready) begin
      map_q.push_back(map_data);
    end
    if (res_valid && res_ready) begin
      res_q.push_back(res_data);
    end

    errors      <= errors + n_err;
    retired     <= retired + n_pop;
    completed   <= completed + n_done;
    traps_taken <= traps_taken + n_trap;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      map_q.delete();
      res_q.delete();
    end else begin
      step_model();
    end
  end

endmodule

// File: test/tb_lsu_writeback.sv
`timescale 1ns/1ps
`include "lsu_remap_macros.svh"

module tb_lsu_writeback
  import lsu_remap_pkg::*;
();

  localparam int NUM_OPS    = 300;
  localparam int CLK_PERIOD = 4;
  localparam int TIMEOUT_NS = NUM_OPS * 40 * CLK_PERIOD;

  logic                                       clk;
  logic                                       rst;
  logic                                       map_valid;
  logic                                       map_ready;
  lsu_map_info_t                              map_data;
  logic                                       res_valid;
  logic                                       res_ready;
  uop_lsu_t                                   res_data;
  logic [`NUM_LSU-1:0]                        result_valid;
  logic [`NUM_LSU-1:0][`ROB_DEPTH_WIDTH-1:0]  result_rob_entry;
  logic [`NUM_LSU-1:0]                        result_w_valid;
  logic [`NUM_LSU-1:0][`VLEN-1:0]             result_w_data;
  logic [`NUM_LSU-1:0]                        result_ready;
  logic                                       trap_valid;
  logic [`ROB_DEPTH_WIDTH-1:0]                trap_rob_entry;
  logic                                       trap_ready;

  int chk_errors;
  int retired;
  int completed;
  int traps_taken;
  int tb_errors;
  int exp_completions;

  lsu_map_info_t rec_list[NUM_OPS];
  uop_lsu_t      res_list[NUM_OPS];

  lsu_writeback_top dut0 (.*);

  lsu_writeback_checker checker0 (
    .errors      (chk_errors),
    .retired     (retired),
    .completed   (completed),
    .traps_taken (traps_taken),
    .*
  );

  bind lsu_remap lsu_writeback_asserts asserts0 (
    .clk              (tb_lsu_writeback.clk),
    .rst              (tb_lsu_writeback.rst),
    .pop_mapinfo      (pop_mapinfo),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_w_data    (result_w_data),
    .trap_valid       (trap_valid),
    .trap_ready       (trap_ready),
    .trap_rob_entry   (trap_rob_entry)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired with %0d of %0d operations retired", retired, NUM_OPS);
    $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    $display("TEST FAILED");
    $finish;
  end

  function automatic int check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %0h, got %0h at %0t", name, expected, actual, $time);
      return 1;
    end
    return 0;
  endfunction

  // records and their LSU results in matching order
  task automatic build_ops();
    int            kind;
    logic          trap;
    logic          mismatch;
    lsu_map_info_t m;
    uop_lsu_t      r;

    for (int k = 0; k < NUM_OPS; k++) begin
      kind     = $urandom_range(0, 9);
      trap     = ($urandom_range(0, 11) == 0);
      mismatch = ($urandom_range(0, 7) == 0);
      m.valid               = (kind >= 2);
      m.rob_entry           = `ROB_DEPTH_WIDTH'(k);
      m.lsu_class           = (kind >= 6) ? is_store : is_load;
      m.vregfile_write_addr = `VREG_ADDR_WIDTH'($urandom());
      r.trap_valid           = trap;
      r.vregfile_write_valid = 1'($urandom_range(0, 1));
      r.vregfile_write_addr  = mismatch ? m.vregfile_write_addr + 1'b1 : m.vregfile_write_addr;
      r.vregfile_write_data  = `VLEN'($urandom());
      r.vstore_last          = 1'($urandom_range(0, 1));
      if (!m.valid) begin
        // junk result dropped with its record
        r.trap_valid = 1'($urandom_range(0, 1));
      end else if (!trap) begin
        if (m.lsu_class == is_load) begin
          r.vregfile_write_valid = 1'b1;
        end else begin
          r.vstore_last = 1'b1;
        end
        exp_completions++;
      end
      rec_list[k] = m;
      res_list[k] = r;
    end
  endtask

  task automatic check_reset_state();
    tb_errors += check_value("result_valid", '0, result_valid);
    tb_errors += check_value("trap_valid", 1'b0, trap_valid);
    tb_errors += check_value("map_ready", 1'b1, map_ready);
  endtask

  task automatic run_traffic();
    int                  recs_sent;
    int                  res_sent;
    logic [`NUM_LSU-1:0] ready_bits;

    recs_sent = 0;
    res_sent  = 0;
    while (retired < NUM_OPS) begin
      @(posedge clk);
      if (map_valid && map_ready) begin
        recs_sent++;
      end
      if (res_valid && res_ready) begin
        res_sent++;
      end
      // a stalled push holds its data
      if (!(map_valid && !map_ready)) begin
        if (recs_sent < NUM_OPS && $urandom_range(0, 3) != 0) begin
          map_valid <= 1'b1;
          map_data  <= rec_list[recs_sent];
        end else begin
          map_valid <= 1'b0;
        end
      end
      // result only after its record went in
      if (!(res_valid && !res_ready)) begin
        if (res_sent < recs_sent && $urandom_range(0, 1) == 0) begin
          res_valid <= 1'b1;
          res_data  <= res_list[res_sent];
        end else begin
          res_valid <= 1'b0;
        end
      end
      for (int i = 0; i < `NUM_LSU; i++) begin
        ready_bits[i] = ($urandom_range(0, 3) != 0);
      end
      result_ready <= ready_bits;
      trap_ready   <= ($urandom_range(0, 2) == 0);
    end
  endtask

  initial begin
    void'($urandom(32'hfe3e));
    rst             = 1'b1;
    map_valid       = 1'b0;
    map_data        = '0;
    res_valid       = 1'b0;
    res_data        = '0;
    result_ready    = '0;
    trap_ready      = 1'b0;
    tb_errors       = 0;
    exp_completions = 0;
    build_ops();
    repeat (4) @(posedge clk);
    check_reset_state();
    rst <= 1'b0;
    run_traffic();
    repeat (2) @(posedge clk);
    tb_errors += check_value("result_valid", '0, result_valid);
    tb_errors += check_value("trap_valid", 1'b0, trap_valid);
    tb_errors += check_value("res_ready", 1'b1, res_ready);
    tb_errors += check_value("completions", exp_completions, completed);
    $display("errors: checker %0d, testbench %0d (completions %0d, traps %0d)",
             chk_errors, tb_errors, completed, traps_taken);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/lsu_remap_pkg.sv
design/lsu_multipop_fifo.sv
design/lsu_remap.sv
design/lsu_writeback_top.sv
test/lsu_writeback_asserts.sv
test/lsu_writeback_checker.sv
test/tb_lsu_writeback.sv
